/* Makefile */
VERILATOR  := verilator
TOP        := cache_tb
RTL_TOP    := cache_top
FILELIST   := cache_ctrl.f
OBJ_DIR    := obj_dir
LOG        := sim.log
BUILD_FLAGS := --binary --timing -j 0 -Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

  typedef enum logic [1:0] {
    OP_CPU_READ,
    OP_CPU_WRITE,
    OP_CTRL_READ
  } op_e;

  // Counter event that a processor access should raise
  typedef enum logic [2:0] {
    EV_NONE,
    EV_READ_HIT,
    EV_READ_MISS,
    EV_WRITE_HIT,
    EV_WRITE_MISS
  } event_e;

  typedef struct packed {
    op_e                          op;
    logic [cache_pkg::ADDR_W-1:0] addr;
    logic [cache_pkg::DATA_W-1:0] wdata;
    logic [cache_pkg::DATA_W-1:0] expected;
    event_e                       ev;
  } entry_t;

  localparam int ACK_TIMEOUT = 20;

  logic                              clk;
  logic                              arst;
  logic                              cpu_req;
  logic                              cpu_we;
  logic [cache_pkg::ADDR_W-1:0]      cpu_addr;
  logic [cache_pkg::DATA_W-1:0]      cpu_wdata;
  logic [cache_pkg::DATA_W-1:0]      cpu_rdata;
  logic                              cpu_ack;
  logic                              mem_req;
  logic                              mem_we;
  logic [cache_pkg::ADDR_W-1:0]      mem_addr;
  logic [cache_pkg::DATA_W-1:0]      mem_wdata;
  logic [cache_pkg::DATA_W-1:0]      mem_rdata;
  logic                              mem_ack;
  logic                              ctrl_req;
  logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr;
  logic [cache_pkg::DATA_W-1:0]      ctrl_rdata;
  logic                              ctrl_ack;

  entry_t      stim_q[$];
  int          error_count;
  int          pass_count;
  logic [31:0] read_hits;
  logic [31:0] read_misses;
  logic [31:0] write_hits;
  logic [31:0] write_misses;

  int          mem_acks = 0;
  logic        mem_last_we;
  logic [15:0] mem_last_addr;
  logic [31:0] mem_last_wdata;

  cache_top u_dut (
    .clk_i        (clk),
    .arst_i       (arst),
    .cpu_req_i    (cpu_req),
    .cpu_we_i     (cpu_we),
    .cpu_addr_i   (cpu_addr),
    .cpu_wdata_i  (cpu_wdata),
    .cpu_rdata_o  (cpu_rdata),
    .cpu_ack_o    (cpu_ack),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata),
    .mem_ack_i    (mem_ack),
    .ctrl_req_i   (ctrl_req),
    .ctrl_addr_i  (ctrl_addr),
    .ctrl_rdata_o (ctrl_rdata),
    .ctrl_ack_o   (ctrl_ack)
  );

  mem_model u_mem (
    .clk_i   (clk),
    .arst_i  (arst),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata),
    .ack_o   (mem_ack)
  );

  always #50 clk = ~clk;

  // Records each completed memory access in the middle of its ack cycle
  always @(negedge clk) begin
    if (!arst && mem_req && mem_ack) begin
      mem_acks       = mem_acks + 1;
      mem_last_we    = mem_we;
      mem_last_addr  = mem_addr;
      mem_last_wdata = mem_wdata;
    end
  end

  // Value of a word in memory that was never written
  function automatic logic [31:0] mem_rule(input logic [15:0] addr);
    return {16'h0000, addr} ^ 32'hA5A5_0000;
  endfunction

  // Counter reads follow the running totals kept from the table
  function automatic logic [31:0] counter_expect(input logic [3:0] caddr,
                                                 input logic [31:0] fallback);
    case (caddr)
      cache_pkg::CTRL_RW_HIT:     return read_hits + write_hits;
      cache_pkg::CTRL_RW_MISS:    return read_misses + write_misses;
      cache_pkg::CTRL_READ_HIT:   return read_hits;
      cache_pkg::CTRL_READ_MISS:  return read_misses;
      cache_pkg::CTRL_WRITE_HIT:  return write_hits;
      cache_pkg::CTRL_WRITE_MISS: return write_misses;
      default:                    return fallback;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic count_event(input event_e ev);
    case (ev)
      EV_READ_HIT:   read_hits = read_hits + 1;
      EV_READ_MISS:  read_misses = read_misses + 1;
      EV_WRITE_HIT:  write_hits = write_hits + 1;
      EV_WRITE_MISS: write_misses = write_misses + 1;
      default:       ;
    endcase
  endtask

  task automatic clear_totals();
    read_hits    = 32'd0;
    read_misses  = 32'd0;
    write_hits   = 32'd0;
    write_misses = 32'd0;
  endtask

  task automatic add_entry(input op_e op, input logic [15:0] addr, input logic [31:0] wdata,
                           input logic [31:0] expected, input event_e ev);
    entry_t e;
    e.op       = op;
    e.addr     = addr;
    e.wdata    = wdata;
    e.expected = expected;
    e.ev       = ev;
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    // Miss then hit on the same word
    add_entry(OP_CPU_READ, 16'h0010, 32'h0, mem_rule(16'h0010), EV_READ_MISS);
    add_entry(OP_CPU_READ, 16'h0010, 32'h0, mem_rule(16'h0010), EV_READ_HIT);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_READ_MISS), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_READ_HIT), 32'h0, 32'h0, EV_NONE);
    // Write-through to a cached word and to an uncached one
    add_entry(OP_CPU_WRITE, 16'h0010, 32'h1234_5678, 32'h0, EV_WRITE_HIT);
    add_entry(OP_CPU_READ, 16'h0010, 32'h0, 32'h1234_5678, EV_READ_HIT);
    add_entry(OP_CPU_WRITE, 16'h0025, 32'hCAFE_0025, 32'h0, EV_WRITE_MISS);
    add_entry(OP_CPU_READ, 16'h0025, 32'h0, 32'hCAFE_0025, EV_READ_MISS);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_WRITE_HIT), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_WRITE_MISS), 32'h0, 32'h0, EV_NONE);
    // Same index and different tags so every read evicts the other word
    add_entry(OP_CPU_READ, 16'h0103, 32'h0, mem_rule(16'h0103), EV_READ_MISS);
    add_entry(OP_CPU_READ, 16'h0203, 32'h0, mem_rule(16'h0203), EV_READ_MISS);
    add_entry(OP_CPU_READ, 16'h0103, 32'h0, mem_rule(16'h0103), EV_READ_MISS);
    add_entry(OP_CPU_READ, 16'h0203, 32'h0, mem_rule(16'h0203), EV_READ_MISS);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_READ_MISS), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_RW_HIT), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_RW_MISS), 32'h0, 32'h0, EV_NONE);
    // Clear the counters and then invalidate a line that hits
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_RST_CNTRS), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_RW_HIT), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_RW_MISS), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_READ_MISS), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CPU_READ, 16'h0025, 32'h0, 32'hCAFE_0025, EV_READ_HIT);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_INVALIDATE), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CPU_READ, 16'h0025, 32'h0, 32'hCAFE_0025, EV_READ_MISS);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_READ_HIT), 32'h0, 32'h0, EV_NONE);
    add_entry(OP_CTRL_READ, 16'(cache_pkg::CTRL_READ_MISS), 32'h0, 32'h0, EV_NONE);
    // Unmapped control addresses return the version word
    add_entry(OP_CTRL_READ, 16'd12, 32'h0, 32'h0001_0000, EV_NONE);
    add_entry(OP_CTRL_READ, 16'd15, 32'h0, 32'h0001_0000, EV_NONE);
  endtask

  // Polls once per cycle 1 ns after the edge until the ack or the timeout
  task automatic wait_ack(input bit ctrl_side, output bit got, output int cycles);
    got    = 1'b0;
    cycles = 0;
    while (!got && cycles < ACK_TIMEOUT) begin
      if ((ctrl_side && ctrl_ack) || (!ctrl_side && cpu_ack)) begin
        got = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        cycles++;
      end
    end
  endtask

  initial begin
    entry_t      e;
    int          rnd_init;
    int          cycles;
    bit          got;
    int          errs_before;
    int          mem_before;
    logic [31:0] exp_val;

    rnd_init    = $urandom(32'h682cb98c);
    clk         = 1'b0;
    arst        = 1'b1;
    cpu_req     = 1'b0;
    cpu_we      = 1'b0;
    cpu_addr    = '0;
    cpu_wdata   = '0;
    ctrl_req    = 1'b0;
    ctrl_addr   = '0;
    error_count = 0;
    pass_count  = 0;
    mem_before  = 0;
    exp_val     = 32'h0;
    clear_totals();
    build_table();

    repeat (3) @(posedge clk);
    #1;
    arst = 1'b0;

    foreach (stim_q[i]) begin
      e           = stim_q[i];
      errs_before = error_count;
      // One idle cycle keeps the new strobe clear of the previous ack cycle
      @(posedge clk);
      #1;
      mem_before = mem_acks;
      if (e.op == OP_CTRL_READ) begin
        exp_val   = counter_expect(e.addr[3:0], e.expected);
        ctrl_req  = 1'b1;
        ctrl_addr = e.addr[3:0];
      end else begin
        cpu_req   = 1'b1;
        cpu_we    = (e.op == OP_CPU_WRITE);
        cpu_addr  = e.addr;
        cpu_wdata = e.wdata;
      end
      @(posedge clk);
      #1;
      cpu_req  = 1'b0;
      ctrl_req = 1'b0;
      wait_ack(e.op == OP_CTRL_READ, got, cycles);

      if (!got) begin
        $display("entry %0d: no acknowledge arrived within %0d cycles", i, ACK_TIMEOUT);
        error_count++;
      end else if (e.op == OP_CTRL_READ) begin
        check_value("ctrl_rdata_o", ctrl_rdata, exp_val);
        check_value("ctrl_ack_o delay", cycles, 0);
        if (e.addr[3:0] == cache_pkg::CTRL_RST_CNTRS) begin
          clear_totals();
        end
      end else begin
        if (e.op == OP_CPU_READ) begin
          check_value("cpu_rdata_o", cpu_rdata, e.expected);
        end
        // A read hit answers from the line alone, everything else goes to memory once
        if (e.ev == EV_READ_HIT) begin
          check_value("cpu_ack_o delay", cycles, 1);
          check_value("mem_req_o accesses", mem_acks - mem_before, 0);
        end else begin
          check_value("mem_req_o accesses", mem_acks - mem_before, 1);
          check_value("mem_we_o", 32'(mem_last_we), 32'(e.op == OP_CPU_WRITE));
          check_value("mem_addr_o", 32'(mem_last_addr), 32'(e.addr));
          if (e.op == OP_CPU_WRITE) begin
            check_value("mem_wdata_o", mem_last_wdata, e.wdata);
          end
        end
        count_event(e.ev);
      end

      if (error_count == errs_before) begin
        pass_count++;
        $display("entry %0d %s addr 0x%04h passed", i, e.op.name(), e.addr);
      end else begin
        $display("entry %0d %s addr 0x%04h failed", i, e.op.name(), e.addr);
      end
    end

    $display("%0d of %0d entries passed, %0d errors", pass_count, stim_q.size(), error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* bench/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
  input  logic                          clk_i,
  input  logic                          arst_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [cache_pkg::ADDR_W-1:0]  addr_i,
  input  logic [cache_pkg::DATA_W-1:0]  wdata_i,
  output logic [cache_pkg::DATA_W-1:0]  rdata_o,
  output logic                          ack_o
);

  localparam int WORDS = 1 << cache_pkg::ADDR_W;

  logic [cache_pkg::DATA_W-1:0] store_q [WORDS];
  logic [WORDS-1:0]             written_q;
  logic                         busy_q;
  logic [1:0]                   wait_q;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      busy_q    <= 1'b0;
      wait_q    <= 2'd0;
      ack_o     <= 1'b0;
      rdata_o   <= '0;
      written_q <= '0;
    end else begin
      ack_o <= 1'b0;
      // The request is still high in the ack cycle and must not start a new access
      if (req_i && !ack_o) begin
        if (!busy_q) begin
          // Latency of 1 to 4 cycles is picked when the request is first seen
          busy_q <= 1'b1;
          wait_q <= 2'($urandom % 4);
        end else if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          busy_q <= 1'b0;
          ack_o  <= 1'b1;
          if (we_i) begin
            store_q[addr_i]   <= wdata_i;
            written_q[addr_i] <= 1'b1;
          end else if (written_q[addr_i]) begin
            rdata_o <= store_q[addr_i];
          end else begin
            // Words never written hold a pattern made from their own address
            rdata_o <= {{(cache_pkg::DATA_W-cache_pkg::ADDR_W){1'b0}}, addr_i} ^
                       32'hA5A5_0000;
          end
        end
      end
    end
  end

endmodule

/* cache_ctrl.f */
hdl/cache_pkg.sv
hdl/cache_line_store.sv
hdl/cache_core.sv
hdl/cache_perf_ctrl.sv
hdl/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

/* hdl/cache_core.sv */
`timescale 1ns/1ps

module cache_core (
  input  logic                          clk_i,
  input  logic                          arst_i,

  // Processor port
  input  logic                          cpu_req_i,
  input  logic                          cpu_we_i,
  input  logic [cache_pkg::ADDR_W-1:0]  cpu_addr_i,
  input  logic [cache_pkg::DATA_W-1:0]  cpu_wdata_i,
  output logic [cache_pkg::DATA_W-1:0]  cpu_rdata_o,
  output logic                          cpu_ack_o,

  // Memory port
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [cache_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic [cache_pkg::DATA_W-1:0]  mem_wdata_o,
  input  logic [cache_pkg::DATA_W-1:0]  mem_rdata_i,
  input  logic                          mem_ack_i,

  // Line store lookup and fill
  output logic [cache_pkg::IDX_W-1:0]   lookup_idx_o,
  output logic [cache_pkg::TAG_W-1:0]   lookup_tag_o,
  input  logic                          hit_i,
  input  logic [cache_pkg::DATA_W-1:0]  line_data_i,
  output logic                          fill_o,
  output logic [cache_pkg::IDX_W-1:0]   fill_idx_o,
  output logic [cache_pkg::TAG_W-1:0]   fill_tag_o,
  output logic [cache_pkg::DATA_W-1:0]  fill_data_o,

  // Event strobes for the counters
  output logic                          read_hit_o,
  output logic                          read_miss_o,
  output logic                          write_hit_o,
  output logic                          write_miss_o
);

  cache_pkg::core_state_e state_q;

  // High in the cycle after the processor strobe
  logic lookup_q;
  logic wr_hit_q;
  logic accept;

  logic [cache_pkg::ADDR_W-1:0] addr_q;
  logic                         we_q;
  logic [cache_pkg::DATA_W-1:0] wdata_q;
  logic [cache_pkg::DATA_W-1:0] rdata_q;

  assign accept = (state_q == cache_pkg::ST_IDLE) && !lookup_q && cpu_req_i;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q  <= cache_pkg::ST_IDLE;
      lookup_q <= 1'b0;
      wr_hit_q <= 1'b0;
    end else begin
      lookup_q <= accept;
      case (state_q)
        cache_pkg::ST_IDLE: begin
          if (lookup_q) begin
            if (we_q) begin
              state_q  <= cache_pkg::ST_MEM_WRITE;
              wr_hit_q <= hit_i;
            end else if (hit_i) begin
              state_q <= cache_pkg::ST_RESPOND;
            end else begin
              state_q <= cache_pkg::ST_MEM_READ;
            end
          end
        end
        cache_pkg::ST_MEM_READ,
        cache_pkg::ST_MEM_WRITE: begin
          if (mem_ack_i) begin
            state_q <= cache_pkg::ST_RESPOND;
          end
        end
        cache_pkg::ST_RESPOND: state_q <= cache_pkg::ST_IDLE;
        default:               state_q <= cache_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= cpu_addr_i;
      we_q    <= cpu_we_i;
      wdata_q <= cpu_wdata_i;
    end
    if (lookup_q && hit_i) begin
      rdata_q <= line_data_i;
    end else if ((state_q == cache_pkg::ST_MEM_READ) && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign lookup_idx_o = addr_q[cache_pkg::IDX_W-1:0];
  assign lookup_tag_o = addr_q[cache_pkg::ADDR_W-1:cache_pkg::IDX_W];

  assign read_hit_o   = lookup_q && !we_q && hit_i;
  assign read_miss_o  = lookup_q && !we_q && !hit_i;
  assign write_hit_o  = lookup_q && we_q && hit_i;
  assign write_miss_o = lookup_q && we_q && !hit_i;

  // Memory request is held for the whole stay in a memory state
  assign mem_req_o   = (state_q == cache_pkg::ST_MEM_READ) ||
                       (state_q == cache_pkg::ST_MEM_WRITE);
  assign mem_we_o    = (state_q == cache_pkg::ST_MEM_WRITE);
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;

  // Read misses fill with memory data, write hits refresh the line with the new word
  assign fill_o      = mem_ack_i && ((state_q == cache_pkg::ST_MEM_READ) ||
                                     ((state_q == cache_pkg::ST_MEM_WRITE) && wr_hit_q));
  assign fill_idx_o  = addr_q[cache_pkg::IDX_W-1:0];
  assign fill_tag_o  = addr_q[cache_pkg::ADDR_W-1:cache_pkg::IDX_W];
  assign fill_data_o = (state_q == cache_pkg::ST_MEM_WRITE) ? wdata_q : mem_rdata_i;

  assign cpu_ack_o   = (state_q == cache_pkg::ST_RESPOND);
  assign cpu_rdata_o = rdata_q;

endmodule

/* hdl/cache_line_store.sv */
`timescale 1ns/1ps

module cache_line_store (
  input  logic                          clk_i,
  input  logic                          arst_i,

  // Lookup is answered in the same cycle
  input  logic [cache_pkg::IDX_W-1:0]   lookup_idx_i,
  input  logic [cache_pkg::TAG_W-1:0]   lookup_tag_i,
  output logic                          hit_o,
  output logic [cache_pkg::DATA_W-1:0]  rdata_o,

  // Line fill from the engine
  input  logic                          fill_i,
  input  logic [cache_pkg::IDX_W-1:0]   fill_idx_i,
  input  logic [cache_pkg::TAG_W-1:0]   fill_tag_i,
  input  logic [cache_pkg::DATA_W-1:0]  fill_data_i,

  // Clears every valid bit
  input  logic                          invalidate_i
);

  logic [cache_pkg::NUM_LINES-1:0] valid_q;
  logic [cache_pkg::TAG_W-1:0]     tag_q  [cache_pkg::NUM_LINES];
  logic [cache_pkg::DATA_W-1:0]    data_q [cache_pkg::NUM_LINES];

  logic [cache_pkg::TAG_W-1:0]     stored_tag;
  logic                            stored_valid;

  assign stored_tag   = tag_q[lookup_idx_i];
  assign stored_valid = valid_q[lookup_idx_i];

  assign hit_o   = stored_valid && (stored_tag == lookup_tag_i);
  assign rdata_o = data_q[lookup_idx_i];

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      // A fill landing in the same cycle is dropped
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[fill_idx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      tag_q[fill_idx_i]  <= fill_tag_i;
      data_q[fill_idx_i] <= fill_data_i;
    end
  end

endmodule

/* hdl/cache_perf_ctrl.sv */
`timescale 1ns/1ps

module cache_perf_ctrl (
  input  logic                              clk_i,
  input  logic                              arst_i,

  // The control port is read only
  input  logic                              ctrl_req_i,
  input  logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr_i,
  output logic [cache_pkg::DATA_W-1:0]      ctrl_rdata_o,
  output logic                              ctrl_ack_o,

  // Event strobes from the engine
  input  logic                              read_hit_i,
  input  logic                              read_miss_i,
  input  logic                              write_hit_i,
  input  logic                              write_miss_i,

  output logic                              invalidate_o
);

  cache_pkg::ctrl_addr_e addr_sel;

  logic [cache_pkg::DATA_W-1:0] read_hit_cnt;
  logic [cache_pkg::DATA_W-1:0] read_miss_cnt;
  logic [cache_pkg::DATA_W-1:0] write_hit_cnt;
  logic [cache_pkg::DATA_W-1:0] write_miss_cnt;
  logic [cache_pkg::DATA_W-1:0] rw_hit_sum;
  logic [cache_pkg::DATA_W-1:0] rw_miss_sum;
  logic [cache_pkg::DATA_W-1:0] read_value;

  logic clear_cnt;
  logic do_invalidate;

  // A clear restarts the counter from the event of the same edge so no strobe is lost
  function automatic logic [cache_pkg::DATA_W-1:0] next_count(
    input logic [cache_pkg::DATA_W-1:0] cnt,
    input logic                         ev,
    input logic                         clr
  );
    logic [cache_pkg::DATA_W-1:0] base;
    base = clr ? '0 : cnt;
    return base + cache_pkg::DATA_W'(ev);
  endfunction

  assign addr_sel      = cache_pkg::ctrl_addr_e'(ctrl_addr_i);
  assign clear_cnt     = ctrl_req_i && (addr_sel == cache_pkg::CTRL_RST_CNTRS);
  assign do_invalidate = ctrl_req_i && (addr_sel == cache_pkg::CTRL_INVALIDATE);

  assign rw_hit_sum  = read_hit_cnt + write_hit_cnt;
  assign rw_miss_sum = read_miss_cnt + write_miss_cnt;

  always_comb begin
    case (addr_sel)
      cache_pkg::CTRL_RW_HIT:     read_value = rw_hit_sum;
      cache_pkg::CTRL_RW_MISS:    read_value = rw_miss_sum;
      cache_pkg::CTRL_READ_HIT:   read_value = read_hit_cnt;
      cache_pkg::CTRL_READ_MISS:  read_value = read_miss_cnt;
      cache_pkg::CTRL_WRITE_HIT:  read_value = write_hit_cnt;
      cache_pkg::CTRL_WRITE_MISS: read_value = write_miss_cnt;
      cache_pkg::CTRL_RST_CNTRS,
      cache_pkg::CTRL_INVALIDATE: read_value = '0;
      default:                    read_value = cache_pkg::CACHE_VERSION;
    endcase
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      read_hit_cnt   <= '0;
      read_miss_cnt  <= '0;
      write_hit_cnt  <= '0;
      write_miss_cnt <= '0;
      ctrl_ack_o     <= 1'b0;
      invalidate_o   <= 1'b0;
    end else begin
      read_hit_cnt   <= next_count(read_hit_cnt, read_hit_i, clear_cnt);
      read_miss_cnt  <= next_count(read_miss_cnt, read_miss_i, clear_cnt);
      write_hit_cnt  <= next_count(write_hit_cnt, write_hit_i, clear_cnt);
      write_miss_cnt <= next_count(write_miss_cnt, write_miss_i, clear_cnt);
      ctrl_ack_o     <= ctrl_req_i;
      invalidate_o   <= do_invalidate;
    end
  end

  // Read data is captured from the counters as they were before this edge
  always_ff @(posedge clk_i) begin
    if (ctrl_req_i) begin
      ctrl_rdata_o <= read_value;
    end
  end

endmodule

/* hdl/cache_pkg.sv */
package cache_pkg;

  // Processor side word address and data
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Direct-mapped geometry with one word per line
  localparam int IDX_W     = 4;
  localparam int TAG_W     = ADDR_W - IDX_W;
  localparam int NUM_LINES = 1 << IDX_W;

  localparam int CTRL_ADDR_W = 4;

  // Returned for any control address that maps to nothing
  localparam logic [DATA_W-1:0] CACHE_VERSION = 32'h0001_0000;

  // Control port address map
  // The clear and invalidate entries act when they are read
  typedef enum logic [CTRL_ADDR_W-1:0] {
    CTRL_RW_HIT     = 4'd0,
    CTRL_RW_MISS    = 4'd1,
    CTRL_READ_HIT   = 4'd2,
    CTRL_READ_MISS  = 4'd3,
    CTRL_WRITE_HIT  = 4'd4,
    CTRL_WRITE_MISS = 4'd5,
    CTRL_RST_CNTRS  = 4'd6,
    CTRL_INVALIDATE = 4'd7
  } ctrl_addr_e;

  // Request FSM of the cache engine
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM_READ,
    ST_MEM_WRITE,
    ST_RESPOND
  } core_state_e;

endpackage

/* hdl/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
  input  logic                              clk_i,
  input  logic                              arst_i,

  input  logic                              cpu_req_i,
  input  logic                              cpu_we_i,
  input  logic [cache_pkg::ADDR_W-1:0]      cpu_addr_i,
  input  logic [cache_pkg::DATA_W-1:0]      cpu_wdata_i,
  output logic [cache_pkg::DATA_W-1:0]      cpu_rdata_o,
  output logic                              cpu_ack_o,

  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [cache_pkg::ADDR_W-1:0]      mem_addr_o,
  output logic [cache_pkg::DATA_W-1:0]      mem_wdata_o,
  input  logic [cache_pkg::DATA_W-1:0]      mem_rdata_i,
  input  logic                              mem_ack_i,

  input  logic                              ctrl_req_i,
  input  logic [cache_pkg::CTRL_ADDR_W-1:0] ctrl_addr_i,
  output logic [cache_pkg::DATA_W-1:0]      ctrl_rdata_o,
  output logic                              ctrl_ack_o
);

  logic [cache_pkg::IDX_W-1:0]  lookup_idx;
  logic [cache_pkg::TAG_W-1:0]  lookup_tag;
  logic                         hit;
  logic [cache_pkg::DATA_W-1:0] line_data;
  logic                         fill;
  logic [cache_pkg::IDX_W-1:0]  fill_idx;
  logic [cache_pkg::TAG_W-1:0]  fill_tag;
  logic [cache_pkg::DATA_W-1:0] fill_data;
  logic                         invalidate;
  logic                         read_hit;
  logic                         read_miss;
  logic                         write_hit;
  logic                         write_miss;

  cache_core u_core (
    .clk_i        (clk_i),
    .arst_i       (arst_i),
    .cpu_req_i    (cpu_req_i),
    .cpu_we_i     (cpu_we_i),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_wdata_i  (cpu_wdata_i),
    .cpu_rdata_o  (cpu_rdata_o),
    .cpu_ack_o    (cpu_ack_o),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_ack_i    (mem_ack_i),
    .lookup_idx_o (lookup_idx),
    .lookup_tag_o (lookup_tag),
    .hit_i        (hit),
    .line_data_i  (line_data),
    .fill_o       (fill),
    .fill_idx_o   (fill_idx),
    .fill_tag_o   (fill_tag),
    .fill_data_o  (fill_data),
    .read_hit_o   (read_hit),
    .read_miss_o  (read_miss),
    .write_hit_o  (write_hit),
    .write_miss_o (write_miss)
  );

  cache_line_store u_store (
    .clk_i        (clk_i),
    .arst_i       (arst_i),
    .lookup_idx_i (lookup_idx),
    .lookup_tag_i (lookup_tag),
    .hit_o        (hit),
    .rdata_o      (line_data),
    .fill_i       (fill),
    .fill_idx_i   (fill_idx),
    .fill_tag_i   (fill_tag),
    .fill_data_i  (fill_data),
    .invalidate_i (invalidate)
  );

  cache_perf_ctrl u_perf (
    .clk_i        (clk_i),
    .arst_i       (arst_i),
    .ctrl_req_i   (ctrl_req_i),
    .ctrl_addr_i  (ctrl_addr_i),
    .ctrl_rdata_o (ctrl_rdata_o),
    .ctrl_ack_o   (ctrl_ack_o),
    .read_hit_i   (read_hit),
    .read_miss_i  (read_miss),
    .write_hit_i  (write_hit),
    .write_miss_i (write_miss),
    .invalidate_o (invalidate)
  );

endmodule
